//--- icache_subsys.f
rtl/icache_pkg.sv
rtl/miss_arbiter.sv
rtl/icache_array.sv
rtl/refill_ctrl.sv
rtl/icache_top.sv
sim/icache_sva.sv
sim/tb_icache.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_icache \
		-Mdir build -o tb_icache -f icache_subsys.f
	./build/tb_icache +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf build sim.log

.PHONY: sim clean

//--- sim/tb_icache.sv
// Drives both fetch ports on the falling edge and serves refills as ~address; addresses must be word aligned

`timescale 1ns/1ps

module tb_icache
  import icache_pkg::*;
();

  localparam int HIT_TIMEOUT = 200;
  localparam int REQ_TIMEOUT = 50;

  logic              cs;
  logic              i_arst_n;
  logic [ADDR_W-1:0] i_rd_addr_0;
  logic [ADDR_W-1:0] i_rd_addr_1;
  logic              i_rd_en_0;
  logic              i_rd_en_1;
  logic [WORD_W-1:0] o_instr_0;
  logic [WORD_W-1:0] o_instr_1;
  logic              o_hit_0;
  logic              o_hit_1;
  logic              o_mem_req;
  logic [ADDR_W-1:0] o_mem_addr;
  logic              i_mem_ack;
  logic [LINE_W-1:0] i_mem_data;

  int                errors = 0;
  int                handshakes = 0;
  int                seed = 32'h730a1ee3;
  logic [ADDR_W-1:0] req_log [$];

  icache_top dut (
    .cs          (cs),
    .i_arst_n    (i_arst_n),
    .i_rd_addr_0 (i_rd_addr_0),
    .i_rd_addr_1 (i_rd_addr_1),
    .i_rd_en_0   (i_rd_en_0),
    .i_rd_en_1   (i_rd_en_1),
    .o_instr_0   (o_instr_0),
    .o_instr_1   (o_instr_1),
    .o_hit_0     (o_hit_0),
    .o_hit_1     (o_hit_1),
    .o_mem_req   (o_mem_req),
    .o_mem_addr  (o_mem_addr),
    .i_mem_ack   (i_mem_ack),
    .i_mem_data  (i_mem_data)
  );

  initial begin
    cs = 1'b0;
    forever #50 cs = ~cs;
  end

  // Every word of the memory image holds the inverse of its byte address
  function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_W-1:0] base);
    logic [LINE_W-1:0] d;
    for (int i = 0; i < LINE_WORDS; i++) begin
      d[i*WORD_W +: WORD_W] = ~(base + 32'(4 * i));
    end
    return d;
  endfunction

  task automatic report_and_finish();
    int sva_errors;
    sva_errors = dut.u_sva.fail_cnt;
    $display("check errors: %0d, assertion errors: %0d", errors, sva_errors);
    if (errors == 0 && sva_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    assert (exp == got) else begin
      errors++;
      $display("FAILED %s: expected %0d got %0d", name, exp, got);
    end
  endtask

  task automatic drive_ports(input logic en0, input logic [ADDR_W-1:0] a0,
                             input logic en1, input logic [ADDR_W-1:0] a1);
    @(negedge cs);
    i_rd_en_0   = en0;
    i_rd_addr_0 = a0;
    i_rd_en_1   = en1;
    i_rd_addr_1 = a1;
  endtask

  // A missing port shows no hit and a zero word
  task automatic expect_miss(input logic chk0, input logic chk1, input string name);
    @(negedge cs);
    assert (!chk0 || (!o_hit_0 && o_instr_0 == '0)) else begin
      errors++;
      $display("FAILED %s: port 0 expected hit 0 word %h got hit %b word %h",
               name, 32'h0, o_hit_0, o_instr_0);
    end
    assert (!chk1 || (!o_hit_1 && o_instr_1 == '0)) else begin
      errors++;
      $display("FAILED %s: port 1 expected hit 0 word %h got hit %b word %h",
               name, 32'h0, o_hit_1, o_instr_1);
    end
  endtask

  task automatic wait_hit(input int port, input string name);
    int t;
    t = 0;
    do begin
      @(negedge cs);
      t++;
    end while (!((port == 0) ? o_hit_0 : o_hit_1) && t < HIT_TIMEOUT);
    if (!((port == 0) ? o_hit_0 : o_hit_1)) begin
      $display("%s: port %0d never saw a hit", name, port);
      errors++;
    end
  endtask

  task automatic check_word(input int port, input logic [ADDR_W-1:0] addr, input string name);
    logic [WORD_W-1:0] got;
    logic              hit;
    got = (port == 0) ? o_instr_0 : o_instr_1;
    hit = (port == 0) ? o_hit_0 : o_hit_1;
    assert (hit) else begin
      errors++;
      $display("FAILED %s: port %0d addr %h expected hit 1 got %b", name, port, addr, hit);
    end
    assert (got == ~addr) else begin
      errors++;
      $display("FAILED %s: port %0d addr %h expected %h got %h", name, port, addr, ~addr, got);
    end
  endtask

  // Memory responder with random ack delays
  initial begin : mem_responder
    int delay;
    int t;
    i_mem_ack  = 1'b0;
    i_mem_data = '0;
    forever begin
      @(negedge cs);
      if (i_arst_n && o_mem_req && !i_mem_ack) begin
        delay = $unsigned($random(seed)) % 6;
        repeat (delay) @(negedge cs);
        i_mem_data = line_data(o_mem_addr);
        i_mem_ack  = 1'b1;
        handshakes++;
        req_log.push_back(o_mem_addr);
        t = 0;
        while (o_mem_req && t < REQ_TIMEOUT) begin
          @(negedge cs);
          t++;
        end
        if (o_mem_req) begin
          $display("memory model: req stayed high long after ack");
          errors++;
        end
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge cs);
        i_mem_ack = 1'b0;
      end
    end
  end

  initial begin : stimulus
    logic [ADDR_W-1:0] a0;
    logic [ADDR_W-1:0] a1;
    int                base_hs;
    int                base_q;
    int                t;
    i_arst_n    = 1'b0;
    i_rd_en_0   = 1'b0;
    i_rd_en_1   = 1'b0;
    i_rd_addr_0 = '0;
    i_rd_addr_1 = '0;
    repeat (3) @(negedge cs);
    i_arst_n = 1'b1;

    // Both ports on line 0x100 with a cold cache
    drive_ports(1'b1, 32'h0000_0104, 1'b1, 32'h0000_0110);
    expect_miss(1'b1, 1'b1, "reset_miss");
    t = 0;
    do begin
      @(negedge cs);
      t++;
    end while (!o_mem_req && t < REQ_TIMEOUT);
    if (!o_mem_req) begin
      $display("reset_miss: o_mem_req never rose");
      errors++;
    end else begin
      assert (o_mem_addr == 32'h0000_0100) else begin
        errors++;
        $display("FAILED reset_miss: expected %h got %h", 32'h0000_0100, o_mem_addr);
      end
    end

    wait_hit(0, "miss_fill");
    check_word(0, 32'h0000_0104, "miss_fill");
    wait_hit(1, "miss_fill");
    check_word(1, 32'h0000_0110, "miss_fill");

    // Whole line resident now
    base_hs = handshakes;
    for (int i = 0; i < LINE_WORDS; i++) begin
      drive_ports(1'b1, 32'h0000_0100 + 32'(4 * i), 1'b0, '0);
      @(negedge cs);
      check_word(0, 32'h0000_0100 + 32'(4 * i), "line_hits");
    end
    check_count("line_hits", base_hs, handshakes);

    // 0x1104 maps to set 0 like 0x104
    drive_ports(1'b1, 32'h0000_1104, 1'b0, '0);
    expect_miss(1'b1, 1'b0, "evict");
    wait_hit(0, "evict");
    check_word(0, 32'h0000_1104, "evict");
    drive_ports(1'b1, 32'h0000_0104, 1'b0, '0);
    expect_miss(1'b1, 1'b0, "evict");
    wait_hit(0, "evict");
    check_word(0, 32'h0000_0104, "evict");
    check_count("evict", base_hs + 2, handshakes);

    // Simultaneous misses on sets 2 and 3
    drive_ports(1'b0, '0, 1'b0, '0);
    repeat (6) @(negedge cs);
    base_hs = handshakes;
    base_q  = req_log.size();
    drive_ports(1'b1, 32'h0000_0344, 1'b1, 32'h0000_0468);
    expect_miss(1'b1, 1'b1, "dual_miss");
    wait_hit(0, "dual_miss");
    check_word(0, 32'h0000_0344, "dual_miss");
    wait_hit(1, "dual_miss");
    check_word(1, 32'h0000_0468, "dual_miss");
    check_count("dual_miss", base_hs + 2, handshakes);
    assert (req_log[base_q] == 32'h0000_0340 && req_log[base_q+1] == 32'h0000_0460) else begin
      errors++;
      $display("FAILED dual_miss: expected %h then %h got %h then %h", 32'h0000_0340,
               32'h0000_0460, req_log[base_q], req_log[base_q+1]);
    end

    // 16 lines over 8 sets make the two ports fight for sets
    for (int n = 0; n < 40; n++) begin
      a0 = 32'h0001_0000 + (($unsigned($random(seed)) % 16) << 5)
           + (($unsigned($random(seed)) % 8) << 2);
      a1 = 32'h0001_0000 + (($unsigned($random(seed)) % 16) << 5)
           + (($unsigned($random(seed)) % 8) << 2);
      drive_ports(1'b1, a0, 1'b1, a1);
      wait_hit(0, "random");
      check_word(0, a0, "random");
      wait_hit(1, "random");
      check_word(1, a1, "random");
    end

    drive_ports(1'b0, '0, 1'b0, '0);
    repeat (10) @(negedge cs);
    report_and_finish();
  end

endmodule

//--- sim/icache_sva.sv
// Bound into icache_top; the hit check assumes memory returns the inverse of each word address

`timescale 1ns/1ps

module icache_sva
  import icache_pkg::*;
(
  input logic              cs,
  input logic              i_arst_n,
  input logic              o_mem_req,
  input logic [ADDR_W-1:0] o_mem_addr,
  input logic              i_mem_ack,
  input logic [ADDR_W-1:0] i_rd_addr_0,
  input logic [ADDR_W-1:0] i_rd_addr_1,
  input logic              o_hit_0,
  input logic              o_hit_1,
  input logic [WORD_W-1:0] o_instr_0,
  input logic [WORD_W-1:0] o_instr_1
);

  int fail_cnt = 0;

  // Phase 1 holds until memory answers
  a_req_hold: assert property (@(posedge cs) disable iff (!i_arst_n)
    o_mem_req && !i_mem_ack |=> o_mem_req)
  else begin
    fail_cnt++;
    $error("mem req dropped before ack");
  end

  // New request only after ack has returned low
  a_req_rise: assert property (@(posedge cs) disable iff (!i_arst_n)
    $rose(o_mem_req) |-> !$past(i_mem_ack))
  else begin
    fail_cnt++;
    $error("mem req rose while ack was high");
  end

  a_addr_stable: assert property (@(posedge cs) disable iff (!i_arst_n)
    o_mem_req && $past(o_mem_req) |-> $stable(o_mem_addr))
  else begin
    fail_cnt++;
    $error("mem addr changed during a request");
  end

  a_hit_data_0: assert property (@(posedge cs) disable iff (!i_arst_n)
    o_hit_0 |-> o_instr_0 == ~i_rd_addr_0)
  else begin
    fail_cnt++;
    $error("FAILED hit_data_0: expected %h got %h",
           ~$sampled(i_rd_addr_0), $sampled(o_instr_0));
  end

  a_hit_data_1: assert property (@(posedge cs) disable iff (!i_arst_n)
    o_hit_1 |-> o_instr_1 == ~i_rd_addr_1)
  else begin
    fail_cnt++;
    $error("FAILED hit_data_1: expected %h got %h",
           ~$sampled(i_rd_addr_1), $sampled(o_instr_1));
  end

endmodule

bind icache_top icache_sva u_sva (
  .cs          (cs),
  .i_arst_n    (i_arst_n),
  .o_mem_req   (o_mem_req),
  .o_mem_addr  (o_mem_addr),
  .i_mem_ack   (i_mem_ack),
  .i_rd_addr_0 (i_rd_addr_0),
  .i_rd_addr_1 (i_rd_addr_1),
  .o_hit_0     (o_hit_0),
  .o_hit_1     (o_hit_1),
  .o_instr_0   (o_instr_0),
  .o_instr_1   (o_instr_1)
);

//--- rtl/icache_top.sv
// Two read-port instruction cache; a port must hold rd_en and address until o_hit, one refill outstanding

`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic              cs,
  input  logic              i_arst_n,

  // Fetch ports
  input  logic [ADDR_W-1:0] i_rd_addr_0,
  input  logic [ADDR_W-1:0] i_rd_addr_1,
  input  logic              i_rd_en_0,
  input  logic              i_rd_en_1,
  output logic [WORD_W-1:0] o_instr_0,
  output logic [WORD_W-1:0] o_instr_1,
  output logic              o_hit_0,
  output logic              o_hit_1,

  // Memory bus
  output logic              o_mem_req,
  output logic [ADDR_W-1:0] o_mem_addr,
  input  logic              i_mem_ack,
  input  logic [LINE_W-1:0] i_mem_data
);

  logic                       hit_0;
  logic                       hit_1;
  logic [WORD_W-1:0]          word_0;
  logic [WORD_W-1:0]          word_1;
  logic                       refill_start;
  logic [ADDR_W-OFFSET_W-1:0] refill_line_addr;
  logic                       refill_done;
  logic                       wr_en;
  logic [SET_W-1:0]           wr_set;
  logic [TAG_W-1:0]           wr_tag;
  line_t                      wr_line;

  miss_arbiter u_arbiter (
    .cs                 (cs),
    .i_arst_n           (i_arst_n),
    .i_rd_en_0          (i_rd_en_0),
    .i_rd_en_1          (i_rd_en_1),
    .i_rd_addr_0        (i_rd_addr_0),
    .i_rd_addr_1        (i_rd_addr_1),
    .i_hit_0            (hit_0),
    .i_hit_1            (hit_1),
    .i_refill_done      (refill_done),
    .o_refill_start     (refill_start),
    .o_refill_line_addr (refill_line_addr)
  );

  icache_array u_array (
    .cs        (cs),
    .i_arst_n  (i_arst_n),
    .i_addr_0  (i_rd_addr_0),
    .i_addr_1  (i_rd_addr_1),
    .i_wr_en   (wr_en),
    .i_wr_set  (wr_set),
    .i_wr_tag  (wr_tag),
    .i_wr_line (wr_line),
    .o_hit_0   (hit_0),
    .o_hit_1   (hit_1),
    .o_word_0  (word_0),
    .o_word_1  (word_1)
  );

  refill_ctrl u_refill (
    .cs                 (cs),
    .i_arst_n           (i_arst_n),
    .i_refill_start     (refill_start),
    .i_refill_line_addr (refill_line_addr),
    .o_refill_done      (refill_done),
    .o_wr_en            (wr_en),
    .o_wr_set           (wr_set),
    .o_wr_tag           (wr_tag),
    .o_wr_line          (wr_line),
    .o_mem_req          (o_mem_req),
    .o_mem_addr         (o_mem_addr),
    .i_mem_ack          (i_mem_ack),
    .i_mem_data         (i_mem_data)
  );

  // Idle ports report no hit and a zero word
  assign o_hit_0   = hit_0 & i_rd_en_0;
  assign o_hit_1   = hit_1 & i_rd_en_1;
  assign o_instr_0 = word_0 & {WORD_W{i_rd_en_0}};
  assign o_instr_1 = word_1 & {WORD_W{i_rd_en_1}};

endmodule

//--- rtl/refill_ctrl.sv
// Four-phase req/ack master for line fills; assumes memory holds data valid while ack is high

`timescale 1ns/1ps

module refill_ctrl
  import icache_pkg::*;
(
  input  logic                       cs,
  input  logic                       i_arst_n,

  // From the arbiter
  input  logic                       i_refill_start,
  input  logic [ADDR_W-OFFSET_W-1:0] i_refill_line_addr,
  output logic                       o_refill_done,

  // Line write toward the array
  output logic                       o_wr_en,
  output logic [SET_W-1:0]           o_wr_set,
  output logic [TAG_W-1:0]           o_wr_tag,
  output line_t                      o_wr_line,

  // Memory bus
  output logic                       o_mem_req,
  output logic [ADDR_W-1:0]          o_mem_addr,
  input  logic                       i_mem_ack,
  input  logic [LINE_W-1:0]          i_mem_data
);

  refill_state_e              state_q;
  refill_state_e              state_d;
  logic                       pend_q;
  logic                       fill_q;
  logic [ADDR_W-OFFSET_W-1:0] addr_q;
  line_t                      line_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RF_IDLE: begin
        if (i_refill_start || pend_q) begin
          state_d = RF_REQ;
        end
      end
      RF_REQ: begin
        if (i_mem_ack) begin
          state_d = RF_DROP;
        end
      end
      RF_DROP: begin
        // New req only once ack has been seen low
        if (!i_mem_ack) begin
          state_d = pend_q ? RF_REQ : RF_IDLE;
        end
      end
      default: begin
        state_d = RF_IDLE;
      end
    endcase
  end

  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= RF_IDLE;
      pend_q  <= 1'b0;
      fill_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      fill_q  <= (state_q == RF_REQ) && i_mem_ack;
      // A start arriving while ack is still settling waits here
      if (state_d == RF_REQ) begin
        pend_q <= 1'b0;
      end else if (i_refill_start) begin
        pend_q <= 1'b1;
      end
    end
  end

  // Line address and returned data
  always_ff @(posedge cs) begin
    if (i_refill_start) begin
      addr_q <= i_refill_line_addr;
    end
    if ((state_q == RF_REQ) && i_mem_ack) begin
      line_q <= i_mem_data;
    end
  end

  assign o_mem_req  = (state_q == RF_REQ);
  assign o_mem_addr = {addr_q, {OFFSET_W{1'b0}}};

  // Write and done share the pulse after ack
  assign o_wr_en       = fill_q;
  assign o_refill_done = fill_q;
  assign o_wr_set      = addr_q[SET_W-1:0];
  assign o_wr_tag      = addr_q[SET_W +: TAG_W];
  assign o_wr_line     = line_q;

endmodule

//--- rtl/icache_array.sv
// Direct-mapped tag and data storage with two combinational lookups and one refill write; only valid bits reset

`timescale 1ns/1ps

module icache_array
  import icache_pkg::*;
(
  input  logic              cs,
  input  logic              i_arst_n,

  // Lookup ports
  input  logic [ADDR_W-1:0] i_addr_0,
  input  logic [ADDR_W-1:0] i_addr_1,

  // Line write from the refill controller
  input  logic              i_wr_en,
  input  logic [SET_W-1:0]  i_wr_set,
  input  logic [TAG_W-1:0]  i_wr_tag,
  input  line_t             i_wr_line,

  output logic              o_hit_0,
  output logic              o_hit_1,
  output logic [WORD_W-1:0] o_word_0,
  output logic [WORD_W-1:0] o_word_1
);

  logic [NUM_SETS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_q  [NUM_SETS];
  line_t               data_q [NUM_SETS];

  // Port signals gathered so both lookups share one description
  logic [ADDR_W-1:0]   addr   [2];
  logic                hit    [2];
  logic [WORD_W-1:0]   word   [2];

  assign addr[0] = i_addr_0;
  assign addr[1] = i_addr_1;

  for (genvar p = 0; p < 2; p++) begin : g_lookup
    logic [TAG_W-1:0]               lk_tag;
    logic [SET_W-1:0]               lk_set;
    logic [OFFSET_W-BYTE_OFF_W-1:0] lk_word;

    // tag | set | word | byte
    assign lk_tag  = addr[p][ADDR_W-1 -: TAG_W];
    assign lk_set  = addr[p][OFFSET_W +: SET_W];
    assign lk_word = addr[p][BYTE_OFF_W +: OFFSET_W-BYTE_OFF_W];

    always_comb begin
      hit[p] = valid_q[lk_set] && (tag_q[lk_set] == lk_tag);
      if (hit[p]) begin
        word[p] = data_q[lk_set][lk_word];
      end else begin
        word[p] = '0;
      end
    end
  end

  assign o_hit_0  = hit[0];
  assign o_hit_1  = hit[1];
  assign o_word_0 = word[0];
  assign o_word_1 = word[1];

  // Valid bits
  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= '0;
    end else if (i_wr_en) begin
      valid_q[i_wr_set] <= 1'b1;
    end
  end

  // Tag and line storage replaced whole on refill
  always_ff @(posedge cs) begin
    if (i_wr_en) begin
      tag_q[i_wr_set]  <= i_wr_tag;
      data_q[i_wr_set] <= i_wr_line;
    end
  end

endmodule

//--- rtl/miss_arbiter.sv
// Serves one refill at a time with port 0 priority; a dropped read during a refill does not cancel it

`timescale 1ns/1ps

module miss_arbiter
  import icache_pkg::*;
(
  input  logic                       cs,
  input  logic                       i_arst_n,

  // Fetch side
  input  logic                       i_rd_en_0,
  input  logic                       i_rd_en_1,
  input  logic [ADDR_W-1:0]          i_rd_addr_0,
  input  logic [ADDR_W-1:0]          i_rd_addr_1,

  // Lookup result from the array
  input  logic                       i_hit_0,
  input  logic                       i_hit_1,

  // Refill controller
  input  logic                       i_refill_done,
  output logic                       o_refill_start,
  output logic [ADDR_W-OFFSET_W-1:0] o_refill_line_addr
);

  logic                       miss_0;
  logic                       miss_1;
  logic [ADDR_W-OFFSET_W-1:0] grant_line;

  logic                       busy_q;
  logic                       start_q;
  logic [ADDR_W-OFFSET_W-1:0] line_q;

  // A miss is an enabled read without a hit
  assign miss_0 = i_rd_en_0 & ~i_hit_0;
  assign miss_1 = i_rd_en_1 & ~i_hit_1;

  // Fixed priority with port 0 first
  always_comb begin
    if (miss_0) begin
      grant_line = i_rd_addr_0[ADDR_W-1:OFFSET_W];
    end else begin
      grant_line = i_rd_addr_1[ADDR_W-1:OFFSET_W];
    end
  end

  // Busy from accept until refill_done; the cycle after done is idle
  // so the array can show the new hit before any miss is sampled
  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (busy_q) begin
        if (i_refill_done) begin
          busy_q <= 1'b0;
        end
      end else if (miss_0 || miss_1) begin
        busy_q  <= 1'b1;
        start_q <= 1'b1;
      end
    end
  end

  // Held line address
  always_ff @(posedge cs) begin
    if (!busy_q && (miss_0 || miss_1)) begin
      line_q <= grant_line;
    end
  end

  assign o_refill_start     = start_q;
  assign o_refill_line_addr = line_q;

endmodule

//--- rtl/icache_pkg.sv
// Fixed cache geometry for 32-bit byte addresses; changing a value here requires all derived widths to stay consistent

package icache_pkg;

  // Address and instruction word
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // Line geometry of 8 words with 32 bits each
  localparam int LINE_WORDS = 8;
  localparam int LINE_W = LINE_WORDS * WORD_W;

  // Direct mapped with one line per set
  localparam int NUM_SETS = 8;
  localparam int SET_W = $clog2(NUM_SETS);

  // Byte offset within a line splits into word index and byte in word
  localparam int OFFSET_W = $clog2(LINE_W / 8);
  localparam int BYTE_OFF_W = OFFSET_W - $clog2(LINE_WORDS);

  // Everything above set and offset is tag
  localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;

  // Word 0 sits in the least significant 32 bits
  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

  // Refill controller handshake phases
  typedef enum logic [1:0] {
    RF_IDLE,
    // req high, waiting for memory ack
    RF_REQ,
    // req low, waiting for ack to return low
    RF_DROP
  } refill_state_e;

endpackage
